// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int offset_width  = 2;                  // word offset within a line
    localparam int line_words    = 1 << offset_width;
    localparam int i_index_width = 2;
    localparam int d_index_width = 2;
    localparam int i_sets        = 1 << i_index_width;
    localparam int d_sets        = 1 << d_index_width;
    localparam int i_tag_width   = 32 - i_index_width - offset_width - 2;
    localparam int d_tag_width   = 32 - d_index_width - offset_width - 2;

    typedef logic [line_words-1:0][31:0] line_t;

    typedef enum logic [0:0] {
        op_none,
        op_inval_index
    } cache_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_write
    } cache_state_e;

    typedef struct packed {
        logic        req;   // held until addr_ok
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        line_t rdata;
    } mem_resp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [63:0] dout;   // [31:0] is the word at pc
        logic        flag;   // upper word valid
    } fetch_resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wr;
        cache_op_e   op;
        logic        opflag;
    } load_store_req_t;

endpackage

`default_nettype wire

// ==== source/icache.sv ====
`default_nettype none

module icache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_addr,
    input  cache_op_e   fetch_op,
    input  logic        fetch_opflag,
    output logic        fetch_ready,
    output fetch_resp_t fetch_resp,
    output mem_req_t    mem_req,
    input  mem_resp_t   mem_resp
);

    cache_state_e state;
    logic [31:0]  pc_q;
    logic         addr_acked;

    logic [i_sets-1:0]      line_valid;
    logic [i_tag_width-1:0] tag_mem [i_sets];
    line_t                  data_mem [i_sets];

    logic [i_index_width-1:0] in_idx;
    logic [i_index_width-1:0] req_idx;
    logic [i_tag_width-1:0]   req_tag;
    logic [offset_width-1:0]  off;
    logic [offset_width-1:0]  next_off;
    line_t                    cur_line;
    logic                     hit;
    logic                     accept;
    logic                     upper_ok;

    assign in_idx   = fetch_addr[offset_width+2 +: i_index_width];
    assign req_idx  = pc_q[offset_width+2 +: i_index_width];
    assign req_tag  = pc_q[31 -: i_tag_width];
    assign off      = pc_q[2 +: offset_width];
    assign next_off = off + 1'b1;
    assign cur_line = data_mem[req_idx];
    assign hit      = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign upper_ok = off != '1;   // last word has no neighbour in this line

    assign fetch_ready = state == st_idle;
    assign accept      = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            addr_acked <= 1'b0;
            line_valid <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && fetch_opflag && fetch_op == op_inval_index) begin
                        line_valid[in_idx] <= 1'b0;
                    end else if (accept && !fetch_opflag) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        state <= st_idle;
                    end else begin
                        state      <= st_refill;
                        addr_acked <= 1'b0;
                    end
                end
                st_refill: begin
                    if (mem_resp.addr_ok) addr_acked <= 1'b1;
                    if (mem_resp.data_ok) begin
                        line_valid[req_idx] <= 1'b1;
                        state               <= st_lookup;   // answer from the new line
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !fetch_opflag) pc_q <= fetch_addr;
        if (state == st_refill && mem_resp.data_ok) begin
            data_mem[req_idx] <= mem_resp.rdata;
            tag_mem[req_idx]  <= req_tag;
        end
    end

    always_comb begin
        mem_req      = '0;
        mem_req.req  = (state == st_refill) && !addr_acked;
        mem_req.addr = {pc_q[31:offset_width+2], {(offset_width+2){1'b0}}};   // line aligned
    end

    always_comb begin
        fetch_resp.valid = (state == st_lookup) && hit;
        fetch_resp.pc    = pc_q;
        fetch_resp.flag  = upper_ok;
        fetch_resp.dout  = {upper_ok ? cur_line[next_off] : 32'h0, cur_line[off]};
    end

endmodule

`default_nettype wire

// ==== source/dcache.sv ====
`default_nettype none

module dcache
    import cache_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            lsu_valid,
    input  load_store_req_t lsu_req,
    output logic            lsu_ready,
    output logic [31:0]     lsu_rdata,
    output logic            lsu_rvalid,
    output mem_req_t        mem_req,
    input  mem_resp_t       mem_resp
);

    cache_state_e    state;
    load_store_req_t req_q;
    logic            addr_acked;

    logic [d_sets-1:0]      line_valid;
    logic [d_tag_width-1:0] tag_mem [d_sets];
    line_t                  data_mem [d_sets];

    logic [d_index_width-1:0] in_idx;
    logic [d_index_width-1:0] req_idx;
    logic [d_tag_width-1:0]   req_tag;
    logic [offset_width-1:0]  off;
    line_t                    cur_line;
    logic [31:0]              merged;
    logic                     hit;
    logic                     accept;
    logic                     is_op;

    assign in_idx   = lsu_req.addr[offset_width+2 +: d_index_width];
    assign req_idx  = req_q.addr[offset_width+2 +: d_index_width];
    assign req_tag  = req_q.addr[31 -: d_tag_width];
    assign off      = req_q.addr[2 +: offset_width];
    assign cur_line = data_mem[req_idx];
    assign hit      = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);

    assign lsu_ready = state == st_idle;
    assign accept    = lsu_valid && lsu_ready;
    assign is_op     = lsu_req.opflag;

    // store data over the cached word
    always_comb begin
        merged = cur_line[off];
        for (int b = 0; b < 4; b++) begin
            if (req_q.wstrb[b]) merged[8*b +: 8] = req_q.wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            addr_acked <= 1'b0;
            line_valid <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && is_op && lsu_req.op == op_inval_index) begin
                        line_valid[in_idx] <= 1'b0;
                    end else if (accept && !is_op) begin
                        state      <= lsu_req.wr ? st_write : st_lookup;
                        addr_acked <= 1'b0;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        state <= st_idle;
                    end else begin
                        state      <= st_refill;
                        addr_acked <= 1'b0;
                    end
                end
                st_refill: begin
                    if (mem_resp.addr_ok) addr_acked <= 1'b1;
                    if (mem_resp.data_ok) begin
                        line_valid[req_idx] <= 1'b1;
                        state               <= st_lookup;
                    end
                end
                st_write: begin
                    if (mem_resp.addr_ok) addr_acked <= 1'b1;
                    if (mem_resp.data_ok) state <= st_idle;   // no allocate on a miss
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_op) req_q <= lsu_req;
        if (state == st_refill && mem_resp.data_ok) begin
            data_mem[req_idx] <= mem_resp.rdata;
            tag_mem[req_idx]  <= req_tag;
        end
        if (state == st_write && mem_resp.data_ok && hit) begin
            data_mem[req_idx][off] <= merged;
        end
    end

    always_comb begin
        mem_req.req   = (state == st_refill || state == st_write) && !addr_acked;
        mem_req.wr    = state == st_write;
        mem_req.wdata = req_q.wdata;
        mem_req.wstrb = (state == st_write) ? req_q.wstrb : 4'h0;
        if (state == st_write) begin
            mem_req.addr = {req_q.addr[31:2], 2'b00};   // single word
        end else begin
            mem_req.addr = {req_q.addr[31:offset_width+2], {(offset_width+2){1'b0}}};
        end
    end

    assign lsu_rdata  = cur_line[off];
    assign lsu_rvalid = (state == st_lookup) && hit;

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  mem_req_t  i_req,
    output mem_resp_t i_resp,
    input  mem_req_t  d_req,
    output mem_resp_t d_resp,
    output mem_req_t  mem_req,
    input  mem_resp_t mem_resp
);

    typedef enum logic [1:0] {
        gnt_none,
        gnt_icache,
        gnt_dcache
    } grant_e;

    grant_e grant;   // owner of the port until data_ok
    grant_e owner;   // grant as seen this cycle

    // idle port goes to the data side first
    always_comb begin
        owner = grant;
        if (grant == gnt_none) begin
            if (d_req.req) begin
                owner = gnt_dcache;
            end else if (i_req.req) begin
                owner = gnt_icache;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= gnt_none;
        end else if (mem_resp.data_ok) begin
            grant <= gnt_none;   // transaction done, release
        end else begin
            grant <= owner;
        end
    end

    // the side without the grant sees zeros
    always_comb begin
        mem_req = '0;
        i_resp  = '0;
        d_resp  = '0;
        case (owner)
            gnt_dcache: begin
                mem_req = d_req;
                d_resp  = mem_resp;
            end
            gnt_icache: begin
                mem_req = i_req;
                i_resp  = mem_resp;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cache_top.sv ====
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    // fetch side
    input  logic            fetch_valid,
    input  logic [31:0]     fetch_addr,
    input  cache_op_e       fetch_op,
    input  logic            fetch_opflag,
    output logic            fetch_ready,
    output fetch_resp_t     fetch_resp,

    // load/store side
    input  logic            lsu_valid,
    input  load_store_req_t lsu_req,
    output logic            lsu_ready,
    output logic [31:0]     lsu_rdata,
    output logic            lsu_rvalid,

    // external memory
    output mem_req_t        mem_req,
    input  mem_resp_t       mem_resp
);

    mem_req_t  i_mem_req;
    mem_resp_t i_mem_resp;
    mem_req_t  d_mem_req;
    mem_resp_t d_mem_resp;

    icache icache0 (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_op     (fetch_op),
        .fetch_opflag (fetch_opflag),
        .fetch_ready  (fetch_ready),
        .fetch_resp   (fetch_resp),
        .mem_req      (i_mem_req),
        .mem_resp     (i_mem_resp)
    );

    dcache dcache0 (
        .clk        (clk),
        .reset      (reset),
        .lsu_valid  (lsu_valid),
        .lsu_req    (lsu_req),
        .lsu_ready  (lsu_ready),
        .lsu_rdata  (lsu_rdata),
        .lsu_rvalid (lsu_rvalid),
        .mem_req    (d_mem_req),
        .mem_resp   (d_mem_resp)
    );

    mem_arbiter arbiter0 (
        .clk      (clk),
        .reset    (reset),
        .i_req    (i_mem_req),
        .i_resp   (i_mem_resp),
        .d_req    (d_mem_req),
        .d_resp   (d_mem_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

endmodule

`default_nettype wire

// ==== testbench/cache_props.sv ====
`default_nettype none

module cache_props
    import cache_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input mem_req_t  mem_req,
    input mem_resp_t mem_resp,
    input mem_resp_t i_resp,
    input mem_resp_t d_resp
);

    logic outstanding;   // accepted, waiting for data_ok
    int   failures = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_req.req && mem_resp.addr_ok) begin
            outstanding <= 1'b1;
        end else if (mem_resp.data_ok) begin
            outstanding <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req.req && !mem_resp.addr_ok |=> mem_req.req && $stable(mem_req))
    else begin
        $error("memory request dropped or changed before addr_ok");
        failures++;
    end

    no_stray_data: assert property (@(posedge clk) disable iff (reset)
        mem_resp.data_ok |-> outstanding)
    else begin
        $error("data_ok without an outstanding memory transaction");
        failures++;
    end

    // each completion reaches exactly one cache
    single_owner: assert property (@(posedge clk) disable iff (reset)
        mem_resp.data_ok |-> i_resp.data_ok != d_resp.data_ok)
    else begin
        $error("data_ok not routed to exactly one cache");
        failures++;
    end

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !mem_req.req)
    else begin
        $error("memory request active right after reset");
        failures++;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cache_top.sv ====
`default_nettype none

module tb_cache_top;
    import cache_pkg::*;

    localparam int clk_period    = 40;
    localparam int num_tests     = 6;
    localparam int ops_per_test  = 16;
    localparam int txns_per_op   = 4;    // store, reload, invalidate, reload
    localparam int worst_cycles  = 16;   // both delays, lookup, losing the arbiter
    localparam int resp_limit    = 64;
    localparam int watchdog_time = num_tests * ops_per_test * txns_per_op
                                   * worst_cycles * clk_period * 2;

    logic            clk;
    logic            reset;
    logic            fetch_valid;
    logic [31:0]     fetch_addr;
    cache_op_e       fetch_op;
    logic            fetch_opflag;
    logic            fetch_ready;
    fetch_resp_t     fetch_resp;
    logic            lsu_valid;
    load_store_req_t lsu_req;
    logic            lsu_ready;
    logic [31:0]     lsu_rdata;
    logic            lsu_rvalid;
    mem_req_t        mem_req;
    mem_resp_t       mem_resp;

    logic [31:0] ref_mem [int unsigned];     // expected contents by word index
    logic [31:0] mem_store [int unsigned];   // stores the memory has seen
    int errors      = 0;
    int checks      = 0;
    int test_num    = 0;
    int last_checks = 0;
    int last_errors = 0;

    cache_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_op     (fetch_op),
        .fetch_opflag (fetch_opflag),
        .fetch_ready  (fetch_ready),
        .fetch_resp   (fetch_resp),
        .lsu_valid    (lsu_valid),
        .lsu_req      (lsu_req),
        .lsu_ready    (lsu_ready),
        .lsu_rdata    (lsu_rdata),
        .lsu_rvalid   (lsu_rvalid),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp)
    );

    bind mem_arbiter cache_props props0 (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp),
        .i_resp   (i_resp),
        .d_resp   (d_resp)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] default_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = data[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        int unsigned key;
        key = addr >> 2;
        if (ref_mem.exists(key)) return ref_mem[key];
        return default_word(addr);
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        int unsigned key;
        key = addr >> 2;
        if (mem_store.exists(key)) return mem_store[key];
        return default_word(addr);
    endfunction

    // 16 lines over 4 sets, so hits and conflicts both happen
    function automatic logic [31:0] random_addr();
        return 32'h0000_1000 + (($urandom % 64) << 2);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 checks - last_checks, errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input logic expect_hit);
        logic [31:0] hi_exp;
        logic        flag_exp;
        int          waited;
        flag_exp = addr[3:2] != 2'b11;
        hi_exp   = flag_exp ? ref_word(addr + 32'd4) : 32'h0;
        while (!fetch_ready) @(negedge clk);
        fetch_valid  = 1'b1;
        fetch_addr   = addr;
        fetch_op     = op_none;
        fetch_opflag = 1'b0;
        @(negedge clk);
        fetch_valid = 1'b0;
        waited = 0;
        while (!fetch_resp.valid && waited < resp_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!fetch_resp.valid) begin
            $display("fetch of %h got no response within %0d cycles", addr, resp_limit);
            errors++;
        end else begin
            check_value("fetch_resp.pc", fetch_resp.pc, addr);
            check_value("fetch_resp.dout[31:0]", fetch_resp.dout[31:0], ref_word(addr));
            check_value("fetch_resp.dout[63:32]", fetch_resp.dout[63:32], hi_exp);
            check_value("fetch_resp.flag", 32'(fetch_resp.flag), 32'(flag_exp));
            if (expect_hit) check_value("fetch hit latency", waited, 0);
        end
    endtask

    task automatic load_and_check(input logic [31:0] addr);
        int waited;
        while (!lsu_ready) @(negedge clk);
        lsu_valid    = 1'b1;
        lsu_req      = '0;
        lsu_req.addr = addr;
        lsu_req.op   = op_none;
        @(negedge clk);
        lsu_valid = 1'b0;
        waited = 0;
        while (!lsu_rvalid && waited < resp_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!lsu_rvalid) begin
            $display("load of %h got no response within %0d cycles", addr, resp_limit);
            errors++;
        end else begin
            check_value("lsu_rdata", lsu_rdata, ref_word(addr));
        end
    endtask

    task automatic store_bytes(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        int unsigned key;
        int          waited;
        while (!lsu_ready) @(negedge clk);
        lsu_valid     = 1'b1;
        lsu_req       = '0;
        lsu_req.addr  = addr;
        lsu_req.wdata = data;
        lsu_req.wstrb = strb;
        lsu_req.wr    = 1'b1;
        lsu_req.op    = op_none;
        @(negedge clk);
        lsu_valid = 1'b0;
        waited = 0;
        while (!lsu_ready && waited < resp_limit) begin
            if (lsu_rvalid) begin
                $display("lsu_rvalid pulsed during the store to %h", addr);
                errors++;
            end
            @(negedge clk);
            waited++;
        end
        if (!lsu_ready) begin
            $display("store to %h did not complete within %0d cycles", addr, resp_limit);
            errors++;
        end
        key = addr >> 2;
        ref_mem[key] = merge_bytes(ref_word(addr), data, strb);
    endtask

    task automatic invalidate_iline(input logic [31:0] addr);
        while (!fetch_ready) @(negedge clk);
        fetch_valid  = 1'b1;
        fetch_addr   = addr;
        fetch_op     = op_inval_index;
        fetch_opflag = 1'b1;
        @(negedge clk);
        fetch_valid  = 1'b0;
        fetch_opflag = 1'b0;
        check_value("fetch_ready", 32'(fetch_ready), 32'h1);
    endtask

    task automatic invalidate_dline(input logic [31:0] addr);
        while (!lsu_ready) @(negedge clk);
        lsu_valid      = 1'b1;
        lsu_req        = '0;
        lsu_req.addr   = addr;
        lsu_req.op     = op_inval_index;
        lsu_req.opflag = 1'b1;
        @(negedge clk);
        lsu_valid      = 1'b0;
        lsu_req.opflag = 1'b0;
        check_value("lsu_ready", 32'(lsu_ready), 32'h1);
    endtask

    // upper word only when pc is not the last word of its line
    flag_rule: assert property (@(posedge clk) disable iff (reset)
        fetch_resp.valid |-> fetch_resp.flag == (fetch_resp.pc[3:2] != 2'b11)
                             && (fetch_resp.flag || fetch_resp.dout[63:32] == 32'h0))
    else begin
        $display("Mismatch fetch_resp.flag: got %h for pc %h",
                 $sampled(fetch_resp.flag), $sampled(fetch_resp.pc));
        errors++;
    end

    initial begin : memory_model
        mem_req_t    cur;
        int          delay;
        int unsigned key;
        mem_resp = '0;
        forever begin
            @(negedge clk);
            mem_resp.data_ok = 1'b0;
            if (mem_req.req && !reset) begin
                cur   = mem_req;
                delay = $urandom % 3;
                repeat (delay) @(negedge clk);
                mem_resp.addr_ok = 1'b1;
                delay = 1 + $urandom % 4;
                repeat (delay) begin
                    @(negedge clk);
                    mem_resp.addr_ok = 1'b0;
                end
                if (cur.wr) begin
                    key = cur.addr >> 2;
                    mem_store[key] = merge_bytes(model_word(cur.addr), cur.wdata, cur.wstrb);
                end else begin
                    for (int w = 0; w < line_words; w++) begin
                        mem_resp.rdata[w] = model_word(cur.addr + 4 * w);
                    end
                end
                mem_resp.data_ok = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(watchdog_time);
        $display("Timeout: tests still running after %0d time units", watchdog_time);
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [3:0]  s;
        int          total;
        void'($urandom(80013));
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        fetch_op     = op_none;
        fetch_opflag = 1'b0;
        lsu_valid    = 1'b0;
        lsu_req      = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_value("fetch_ready", 32'(fetch_ready), 32'h1);
        check_value("lsu_ready", 32'(lsu_ready), 32'h1);
        check_value("fetch_resp.valid", 32'(fetch_resp.valid), 32'h0);
        check_value("lsu_rvalid", 32'(lsu_rvalid), 32'h0);
        check_value("mem_req.req", 32'(mem_req.req), 32'h0);
        report_test("reset state");

        for (int i = 0; i < ops_per_test; i++) begin
            a = random_addr();
            fetch_and_check(a, 1'b0);
            fetch_and_check(a, 1'b1);   // same line, must hit
        end
        report_test("instruction fetch");

        for (int i = 0; i < ops_per_test; i++) begin
            load_and_check(random_addr());
        end
        report_test("data load");

        for (int i = 0; i < ops_per_test; i++) begin
            a = random_addr();
            d = $urandom;
            s = 4'($urandom);
            store_bytes(a, d, s);
            load_and_check(a);
            invalidate_dline(a);
            load_and_check(a);   // now from memory
        end
        report_test("byte stores");

        for (int i = 0; i < ops_per_test; i++) begin
            a = random_addr();
            d = $urandom;
            s = 4'($urandom);
            store_bytes(a, d, s);
            invalidate_iline(a);
            fetch_and_check(a, 1'b0);
        end
        report_test("cross visibility");

        for (int i = 0; i < ops_per_test; i++) begin
            a = random_addr();
            b = random_addr();
            invalidate_iline(a);
            invalidate_dline(b);
            fork
                fetch_and_check(a, 1'b0);
                load_and_check(b);
            join
        end
        report_test("contention");

        total = errors + dut0.arbiter0.props0.failures;
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/cache_pkg.sv
source/icache.sv
source/dcache.sv
source/mem_arbiter.sv
source/cache_top.sv
testbench/cache_props.sv
testbench/tb_cache_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cache_top -f src.f

# keep running past a failed assertion so the closing counts are printed
result=$(./obj_dir/Vtb_cache_top +verilator+error+limit+1000) || true
echo "$result"

if echo "$result" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
